//--- compile.f
eeprom_pkg.sv
i2c_bit_if.sv
i2c_bit_engine.sv
eeprom_ctrl.sv
eeprom_wr.sv
tb_eeprom_model.sv
tb_eeprom_wr.sv

//--- eeprom_ctrl.sv
module eeprom_ctrl import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wr_data,
    output logic        ack,
    output logic        nack,
    output logic [7:0]  rd_data,
    i2c_bit_if.seq      bus
);

    // one-hot main states
    localparam logic [9:0] idle        = 10'b00_0000_0001;
    localparam logic [9:0] write_start = 10'b00_0000_0010;
    localparam logic [9:0] ctrl_write  = 10'b00_0000_0100;
    localparam logic [9:0] addr_write  = 10'b00_0000_1000;
    localparam logic [9:0] data_write  = 10'b00_0001_0000;
    localparam logic [9:0] read_start  = 10'b00_0010_0000;
    localparam logic [9:0] ctrl_read   = 10'b00_0100_0000;
    localparam logic [9:0] data_read   = 10'b00_1000_0000;
    localparam logic [9:0] stop        = 10'b01_0000_0000;
    localparam logic [9:0] finish      = 10'b10_0000_0000;

    logic [9:0]  state;
    logic        pending;  // command handed to the engine, done not yet seen
    logic        dir_rd;
    logic        fail;
    logic [10:0] addr_r;
    logic [7:0]  data_r;
    logic [7:0]  rd_buf;

    logic        issuing;
    logic        nacked;
    logic [1:0]  cmd_sel;
    byte_word_u  tx_word;

    assign issuing        = (state != idle) && (state != finish);
    assign nacked         = bus.done && bus.slave_ack && (cmd_sel == cmd_write);
    assign bus.cmd_go     = issuing && !pending;
    assign bus.cmd        = cmd_sel;
    assign bus.tx_byte    = tx_word;
    assign bus.master_ack = 1'b1;  // single-byte read ends with NACK

    always_comb begin
        case (state)
            write_start, read_start:                     cmd_sel = cmd_start;
            ctrl_write, addr_write, data_write, ctrl_read: cmd_sel = cmd_write;
            data_read:                                   cmd_sel = cmd_read;
            default:                                     cmd_sel = cmd_stop;
        endcase
    end

    always_comb begin
        tx_word.raw = 8'h00;
        case (state)
            ctrl_write, ctrl_read: begin
                tx_word.ctrl.dev  = device_code;
                tx_word.ctrl.page = addr_r[10:8];
                tx_word.ctrl.rw   = (state == ctrl_read);
            end
            addr_write: tx_word.raw = addr_r[7:0];
            data_write: tx_word.raw = data_r;
            default:    tx_word.raw = 8'h00;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= idle;
            pending <= 1'b0;
            dir_rd  <= 1'b0;
            fail    <= 1'b0;
            ack     <= 1'b0;
            nack    <= 1'b0;
        end else begin
            ack  <= 1'b0;
            nack <= 1'b0;
            if (bus.cmd_go) begin
                pending <= 1'b1;
            end
            if (bus.done) begin
                pending <= 1'b0;
            end
            if (nacked) begin
                fail  <= 1'b1;  // slave refused, close the bus
                state <= stop;
            end else begin
                case (state)
                    idle: begin
                        if (wr || rd) begin
                            dir_rd <= !wr;  // wr wins if both
                            fail   <= 1'b0;
                            state  <= write_start;
                        end
                    end
                    write_start: if (bus.done) state <= ctrl_write;
                    ctrl_write:  if (bus.done) state <= addr_write;
                    addr_write:  if (bus.done) state <= dir_rd ? read_start : data_write;
                    data_write:  if (bus.done) state <= stop;
                    read_start:  if (bus.done) state <= ctrl_read;  // repeated start
                    ctrl_read:   if (bus.done) state <= data_read;
                    data_read:   if (bus.done) state <= stop;
                    stop: begin
                        if (bus.done) begin
                            ack   <= !fail;
                            nack  <= fail;
                            state <= finish;
                        end
                    end
                    finish:  state <= idle;
                    default: state <= idle;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == idle && (wr || rd)) begin
            addr_r <= addr;
            data_r <= wr_data;
        end
        if (state == data_read && bus.done) begin
            rd_buf <= bus.rx_byte;
        end
        if (state == stop && bus.done && dir_rd && !fail) begin
            rd_data <= rd_buf;  // lands with the ack pulse
        end
    end

    // engine answers only what was handed over, and never beside a new strobe
    a_done_outstanding: assert property (@(posedge CLK) disable iff (RESET)
        bus.done |-> pending && !bus.cmd_go);

    a_ack_nack_excl: assert property (@(posedge CLK) disable iff (RESET)
        !(ack && nack));

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    // fixed type code of the 24cxx family
    localparam logic [3:0] device_code = 4'b1010;

    // bit engine commands
    localparam logic [1:0] cmd_start = 2'd0;
    localparam logic [1:0] cmd_stop  = 2'd1;
    localparam logic [1:0] cmd_write = 2'd2;  // byte out, then slave ack in
    localparam logic [1:0] cmd_read  = 2'd3;  // byte in, then master ack out

    // one shift word, seen either as a control byte or as plain data
    typedef union packed {
        struct packed {
            logic [3:0] dev;
            logic [2:0] page;  // addr[10:8]
            logic       rw;    // 1 for read
        } ctrl;
        logic [7:0] raw;
    } byte_word_u;

endpackage

//--- eeprom_wr.sv
module eeprom_wr #(
    parameter int QUARTER_CYCLES = 1
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wr_data,
    input  logic        sda_in,
    output logic        scl,
    output logic        sda_out,
    output logic        sda_en,
    output logic        ack,
    output logic        nack,
    output logic [7:0]  rd_data
);

    i2c_bit_if bit_bus ();

    eeprom_ctrl u_ctrl (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .ack     (ack),
        .nack    (nack),
        .rd_data (rd_data),
        .bus     (bit_bus)
    );

    i2c_bit_engine #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_en  (sda_en),
        .sda_in  (sda_in),
        .bus     (bit_bus)
    );

endmodule

//--- i2c_bit_engine.sv
module i2c_bit_engine import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 1
) (
    input  logic      CLK,
    input  logic      RESET,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_en,
    input  logic      sda_in,
    i2c_bit_if.engine bus
);

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(QUARTER_CYCLES - 1);

    logic          busy;
    logic [1:0]    cmd_r;
    byte_word_u    tx_r;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;     // quarter within the bit
    logic [3:0]    bit_cnt;

    logic          q_end;
    logic          last_bit;
    logic          enter;     // next cycle opens a new quarter
    logic [1:0]    cmd_now;
    byte_word_u    tx_now;
    logic [1:0]    nxt_phase;
    logic [3:0]    nxt_bit;
    logic          nxt_scl;
    logic          nxt_sda_out;
    logic          nxt_sda_en;

    assign q_end    = busy && (qcnt == Q_LAST);
    assign last_bit = (cmd_r == cmd_write || cmd_r == cmd_read) ? (bit_cnt == 4'd8) : 1'b1;
    assign enter    = busy ? (q_end && !(phase == 2'd3 && last_bit)) : bus.cmd_go;

    // first quarter of a command is decoded before cmd_r/tx_r are loaded
    assign cmd_now   = busy ? cmd_r : bus.cmd;
    assign tx_now    = busy ? tx_r : bus.tx_byte;
    assign nxt_phase = busy ? phase + 2'd1 : 2'd0;
    assign nxt_bit   = !busy ? 4'd0 : (phase == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;

    // line levels for the quarter being entered
    always_comb begin
        nxt_scl     = (nxt_phase != 2'd0);  // low only in the first quarter
        nxt_sda_en  = sda_en;
        nxt_sda_out = sda_out;
        case (cmd_now)
            cmd_start: begin
                if (nxt_phase == 2'd0) begin
                    nxt_sda_en  = 1'b1;
                    nxt_sda_out = 1'b1;
                end else if (nxt_phase == 2'd2) begin
                    nxt_sda_out = 1'b0;  // falls under high scl
                end
            end
            cmd_stop: begin
                if (nxt_phase == 2'd0) begin
                    nxt_sda_en  = 1'b1;
                    nxt_sda_out = 1'b0;
                end else if (nxt_phase == 2'd2) begin
                    nxt_sda_en  = 1'b0;  // pull-up gives the rising edge
                    nxt_sda_out = 1'b1;
                end
            end
            cmd_write: begin
                if (nxt_phase == 2'd0) begin
                    if (nxt_bit == 4'd8) begin
                        nxt_sda_en  = 1'b0;  // let the slave ack
                        nxt_sda_out = 1'b1;
                    end else begin
                        nxt_sda_en  = 1'b1;
                        nxt_sda_out = tx_now.raw[3'd7 - nxt_bit[2:0]];  // msb first
                    end
                end
            end
            cmd_read: begin
                if (nxt_phase == 2'd0) begin
                    if (nxt_bit == 4'd8) begin
                        nxt_sda_en  = 1'b1;
                        nxt_sda_out = bus.master_ack;
                    end else begin
                        nxt_sda_en  = 1'b0;
                        nxt_sda_out = 1'b1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy          <= 1'b0;
            qcnt          <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            scl           <= 1'b1;
            sda_out       <= 1'b1;
            sda_en        <= 1'b0;
            bus.done      <= 1'b0;
            bus.slave_ack <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (enter) begin
                scl     <= nxt_scl;
                sda_en  <= nxt_sda_en;
                sda_out <= nxt_sda_out;
            end
            if (!busy) begin
                if (bus.cmd_go) begin
                    busy          <= 1'b1;
                    qcnt          <= '0;
                    phase         <= 2'd0;
                    bit_cnt       <= 4'd0;
                    bus.slave_ack <= 1'b0;
                end
            end else if (q_end) begin
                qcnt    <= '0;
                phase   <= nxt_phase;
                bit_cnt <= nxt_bit;
                if (phase == 2'd2 && cmd_r == cmd_write && bit_cnt == 4'd8) begin
                    bus.slave_ack <= sda_in;  // mid-high sample
                end
                if (phase == 2'd3 && last_bit) begin
                    busy     <= 1'b0;
                    bus.done <= 1'b1;
                end
            end else begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && bus.cmd_go) begin
            cmd_r <= bus.cmd;
            tx_r  <= bus.tx_byte;
        end
        if (q_end && phase == 2'd2 && cmd_r == cmd_read && bit_cnt < 4'd8) begin
            bus.rx_byte <= {bus.rx_byte[6:0], sda_in};
        end
    end

    // data moves only under low scl, edges under high scl belong to start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && !(busy && (cmd_r == cmd_start || cmd_r == cmd_stop)))
            |-> $stable({sda_en, sda_out}));

    a_idle_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> scl);

endmodule

//--- i2c_bit_if.sv
interface i2c_bit_if import eeprom_pkg::*; ();

    // sequencer side
    logic [1:0] cmd;
    logic       cmd_go;      // one-cycle strobe
    byte_word_u tx_byte;
    logic       master_ack;  // level sent in ninth bit of a read

    // engine side
    logic       done;        // one pulse per command
    logic [7:0] rx_byte;
    logic       slave_ack;   // 1 means no ack

    modport seq (
        output cmd,
        output cmd_go,
        output tx_byte,
        output master_ack,
        input  done,
        input  rx_byte,
        input  slave_ack
    );

    modport engine (
        input  cmd,
        input  cmd_go,
        input  tx_byte,
        input  master_ack,
        output done,
        output rx_byte,
        output slave_ack
    );

endinterface

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_eeprom_wr -f compile.f

out=$(./obj_dir/Vtb_eeprom_wr)
echo "$out"

if echo "$out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1

//--- tb_eeprom_model.sv
module tb_eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic ack_enable,
    output logic pull_low
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [2048];
    logic [10:0] ptr;
    logic [7:0]  last_ctrl;
    int          starts;
    int          stops;
    int          proto_errors;

    logic        scl_q;
    logic        sda_q;
    logic [3:0]  cnt;          // scl rises since the last byte boundary
    logic [1:0]  byte_idx;     // 0 control, 1 word address, 2 data
    logic        listening;
    logic        reading;
    logic        master_nack;
    logic [7:0]  rx_sr;
    logic [7:0]  tx_sr;
    logic        pull_r;
    logic        pull_d = 1'b0;

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return (a[7:0] + {a[10:8], 5'd0}) ^ 8'h5a;
    endfunction

    initial begin
        for (int a = 0; a < 2048; a++) begin
            mem[a] = fill_byte(11'(a));
        end
    end

    assign pull_low = pull_d;

    // line moves a little after the edge, while scl is still low
    always @(posedge CLK) begin
        #1;
        pull_d = pull_r;
    end

    always @(posedge CLK) begin
        if (RESET) begin
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            cnt          <= 4'd0;
            byte_idx     <= 2'd0;
            listening    <= 1'b0;
            reading      <= 1'b0;
            master_nack  <= 1'b0;
            pull_r       <= 1'b0;
            ptr          <= 11'd0;
            last_ctrl    <= 8'h00;
            starts       <= 0;
            stops        <= 0;
            proto_errors <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && (sda != sda_q)) begin
                if (cnt > 4'd1) begin
                    proto_errors <= proto_errors + 1;  // edge inside a byte
                end
                if (!sda) begin
                    starts    <= starts + 1;
                    listening <= 1'b1;
                end else begin
                    stops     <= stops + 1;
                    listening <= 1'b0;
                end
                cnt         <= 4'd0;
                byte_idx    <= 2'd0;
                reading     <= 1'b0;
                master_nack <= 1'b0;
                pull_r      <= 1'b0;
            end else if (scl && !scl_q) begin
                if (cnt < 4'd8 && !reading) begin
                    rx_sr <= {rx_sr[6:0], sda};
                end else if (cnt == 4'd8 && reading) begin
                    master_nack <= sda;
                end
                if (cnt < 4'd9) begin
                    cnt <= cnt + 1'b1;
                end
            end else if (!scl && scl_q) begin
                if (cnt == 4'd8) begin
                    pull_r <= 1'b0;
                    if (listening && !reading) begin
                        if (byte_idx == 2'd0) begin
                            last_ctrl <= rx_sr;
                            if (rx_sr[7:4] == 4'b1010 && ack_enable) begin
                                pull_r    <= 1'b1;
                                ptr[10:8] <= rx_sr[3:1];
                                reading   <= rx_sr[0];
                            end else begin
                                listening <= 1'b0;
                            end
                        end else if (!ack_enable) begin
                            listening <= 1'b0;
                        end else if (byte_idx == 2'd1) begin
                            pull_r   <= 1'b1;
                            ptr[7:0] <= rx_sr;
                        end else begin
                            pull_r    <= 1'b1;
                            mem[ptr]  <= rx_sr;
                            ptr[3:0]  <= ptr[3:0] + 4'd1;  // 16-byte page wrap
                        end
                        if (byte_idx != 2'd2) begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end else if (cnt == 4'd9) begin
                    cnt    <= 4'd0;
                    pull_r <= 1'b0;
                    if (listening && reading && !master_nack) begin
                        pull_r <= !mem[ptr][7];
                        tx_sr  <= {mem[ptr][6:0], 1'b0};
                        ptr    <= ptr + 11'd1;
                    end
                end else if (cnt != 4'd0 && listening && reading) begin
                    pull_r <= !tx_sr[7];
                    tx_sr  <= {tx_sr[6:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- tb_eeprom_wr.sv
module tb_eeprom_wr;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int QUARTER_CYCLES = 2;  // slave reacts one clock after scl falls
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MIX_OPS        = 200;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wr_data;
    logic        sda_in;
    logic        scl;
    logic        sda_out;
    logic        sda_en;
    logic        ack;
    logic        nack;
    logic [7:0]  rd_data;
    logic        pull_low;
    logic        ack_enable;

    logic [7:0]  ref_mem [2048];
    int          errors;
    int          timeouts;
    int          exp_starts;
    int          exp_stops;

    assign sda_in = (sda_en ? sda_out : 1'b1) & !pull_low;  // wired-and with pull-up

    eeprom_wr #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) u_eeprom_wr (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_en  (sda_en),
        .ack     (ack),
        .nack    (nack),
        .rd_data (rd_data)
    );

    tb_eeprom_model u_eeprom_model (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda_in),
        .ack_enable (ack_enable),
        .pull_low   (pull_low)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return (a[7:0] + {a[10:8], 5'd0}) ^ 8'h5a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_result(input string name, output bit got_ack, output bit got_nack);
        got_ack  = 1'b0;
        got_nack = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(negedge CLK);
            if (ack || nack) begin
                got_ack  = ack;
                got_nack = nack;
                break;
            end
        end
        assert (got_ack || got_nack) else begin
            $display("%s: neither ack nor nack arrived within %0d cycles", name, TIMEOUT_CYCLES);
            timeouts++;
        end
    endtask

    task automatic start_request(input bit is_write, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        #1;
        wr      = is_write;
        rd      = !is_write;
        addr    = a;
        wr_data = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic write_byte(input string name, input logic [10:0] a, input logic [7:0] d,
                              input bit expect_ack);
        bit got_ack;
        bit got_nack;
        start_request(1'b1, a, d);
        wait_result(name, got_ack, got_nack);
        check_value({name, " ack"}, 32'(expect_ack), 32'(got_ack));
        check_value({name, " nack"}, 32'(!expect_ack), 32'(got_nack));
        if (expect_ack) begin
            ref_mem[a] = d;
        end
        check_value({name, " model memory"}, 32'(ref_mem[a]), 32'(u_eeprom_model.mem[a]));
        check_value({name, " control byte"}, {24'd0, 4'b1010, a[10:8], 1'b0},
                    32'(u_eeprom_model.last_ctrl));
        exp_starts++;
        exp_stops++;
    endtask

    task automatic read_byte(input string name, input logic [10:0] a);
        bit got_ack;
        bit got_nack;
        start_request(1'b0, a, 8'h00);
        wait_result(name, got_ack, got_nack);
        check_value({name, " ack"}, 1, 32'(got_ack));
        check_value({name, " read data"}, 32'(ref_mem[a]), 32'(rd_data));
        check_value({name, " control byte"}, {24'd0, 4'b1010, a[10:8], 1'b1},
                    32'(u_eeprom_model.last_ctrl));
        exp_starts += 2;  // repeated start
        exp_stops++;
    endtask

    initial begin
        logic [10:0] a;
        logic [10:0] recent;
        logic [7:0]  d;
        bit          got_ack;
        bit          got_nack;
        int          extra;
        void'($urandom(32'h22cc8bea));
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = 11'd0;
        wr_data    = 8'h00;
        ack_enable = 1'b1;
        errors     = 0;
        timeouts   = 0;
        exp_starts = 0;
        exp_stops  = 0;
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = fill_byte(11'(i));
        end
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;

        @(negedge CLK);
        check_value("reset scl", 1, 32'(scl));
        check_value("reset sda_out", 1, 32'(sda_out));
        check_value("reset sda_en", 0, 32'(sda_en));
        check_value("reset ack", 0, 32'(ack));
        check_value("reset nack", 0, 32'(nack));

        a = 11'($urandom);
        d = 8'($urandom);
        write_byte("write then read", a, d, 1'b1);
        read_byte("write then read", a);

        // about half the traffic revisits the last written address
        recent = a;
        for (int i = 0; i < MIX_OPS && timeouts == 0; i++) begin
            if ($urandom % 2 == 0) begin
                a = recent;
            end else begin
                a = 11'($urandom);
            end
            if ($urandom % 2 == 0) begin
                d = 8'($urandom);
                write_byte($sformatf("mix %0d", i), a, d, 1'b1);
                recent = a;
            end else begin
                read_byte($sformatf("mix %0d", i), a);
            end
        end

        @(posedge CLK);
        #1;
        ack_enable = 1'b0;
        a = 11'($urandom);
        write_byte("no acknowledge", a, ~ref_mem[a], 1'b0);
        @(posedge CLK);
        #1;
        ack_enable = 1'b1;

        a      = 11'($urandom);
        recent = a ^ 11'h2a5;
        d      = 8'($urandom);
        start_request(1'b1, a, d);
        repeat (20) @(posedge CLK);
        start_request(1'b1, recent, ~d);  // lands mid-transaction
        wait_result("strobe while busy", got_ack, got_nack);
        check_value("strobe while busy ack", 1, 32'(got_ack));
        ref_mem[a] = d;
        exp_starts++;
        exp_stops++;
        extra = 0;
        for (int n = 0; n < 400; n++) begin
            @(negedge CLK);
            if (ack || nack) begin
                extra++;
            end
        end
        check_value("strobe while busy extra pulses", 0, extra);
        check_value("strobe while busy first", 32'(d), 32'(u_eeprom_model.mem[a]));
        check_value("strobe while busy second", 32'(ref_mem[recent]),
                    32'(u_eeprom_model.mem[recent]));

        check_value("protocol errors", 0, u_eeprom_model.proto_errors);
        check_value("start count", exp_starts, u_eeprom_model.starts);
        check_value("stop count", exp_stops, u_eeprom_model.stops);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
